//--- hdl/cap_rf_pkg.sv
/*
 * capability register file shared definitions
 * sizes, capability metadata layout and the folded data parity rule
 */
package cap_rf_pkg;

  // register file geometry, register 0 is hard-wired
  localparam int NumRegs   = 32;
  localparam int AddrWidth = 5;

  // stored data word, parity sits in the top bits
  localparam int DataWidth = 39;
  localparam int ParWidth  = 7;
  localparam int WordWidth = DataWidth - ParWidth;

  // capability metadata
  localparam int CapWidth = 38;

  // revocation bitmap index, 64 entries
  localparam int RvkIdxWidth = 6;

  // one metadata word, seen as a flat vector or as decoded fields
  typedef union packed {
    logic [CapWidth-1:0] raw;
    struct packed {
      logic       valid;
      logic [5:0] perms;
      logic [2:0] otype;
      logic [4:0] exp;
      logic [8:0] top;
      logic [8:0] base;
      logic [4:0] reserved;
    } fields;
  } cap_meta_u;

  localparam cap_meta_u NullCap = '0;

  // bit k is the xor of every data bit j with j mod 7 == k
  function automatic logic [ParWidth-1:0] rf_par7(input logic [WordWidth-1:0] data);
    logic [ParWidth-1:0] par;
    par = '0;
    for (int j = 0; j < WordWidth; j++) begin
      par[j % ParWidth] = par[j % ParWidth] ^ data[j];
    end
    return par;
  endfunction

  // zero data word with the parity of zero
  localparam logic [DataWidth-1:0] ZeroWord = {rf_par7('0), {WordWidth{1'b0}}};

endpackage

//--- hdl/cap_regfile.sv
/*
 * capability register file with data, parity and metadata flops,
 * a load ready vector and revocation bypass onto the read ports
 */
`timescale 1ns/1ps

module cap_regfile (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // read ports
  input  logic [cap_rf_pkg::AddrWidth-1:0]     raddr_a_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]     raddr_b_i,
  output logic [cap_rf_pkg::DataWidth-1:0]     rdata_a_o,
  output logic [cap_rf_pkg::DataWidth-1:0]     rdata_b_o,
  output cap_rf_pkg::cap_meta_u                rcap_a_o,
  output cap_rf_pkg::cap_meta_u                rcap_b_o,
  // parity readback for the fault monitor
  input  logic [cap_rf_pkg::AddrWidth-1:0]     rdbk_addr_i,
  output logic [cap_rf_pkg::ParWidth-1:0]      rdbk_par_o,
  // write port
  input  logic                                 we_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]     waddr_i,
  input  logic [cap_rf_pkg::DataWidth-1:0]     wdata_i,
  input  cap_rf_pkg::cap_meta_u                wcap_i,
  // tag reservation and revocation
  input  logic                                 trsv_en_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]     trsv_addr_i,
  input  logic                                 trvk_en_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]     trvk_addr_i,
  input  logic                                 trvk_clrtag_i,
  // state views
  output logic [cap_rf_pkg::NumRegs-1:0]       rdy_vec_o,
  output logic [cap_rf_pkg::NumRegs-1:0]       cap_valid_o,
  output logic [cap_rf_pkg::NumRegs-1:0]       reg_rdy_o
);

  logic [cap_rf_pkg::DataWidth-1:0] rf_data   [cap_rf_pkg::NumRegs];
  logic [cap_rf_pkg::DataWidth-1:0] rf_data_q [1:cap_rf_pkg::NumRegs-1];
  cap_rf_pkg::cap_meta_u            rf_cap    [cap_rf_pkg::NumRegs];
  cap_rf_pkg::cap_meta_u            rf_cap_q  [1:cap_rf_pkg::NumRegs-1];

  logic [cap_rf_pkg::NumRegs-1:1]   we_dec;
  logic [cap_rf_pkg::NumRegs-1:1]   trsv_dec;
  logic [cap_rf_pkg::NumRegs-1:1]   trvk_dec;
  logic [cap_rf_pkg::NumRegs-1:1]   rdy_q;

  cap_rf_pkg::cap_meta_u            rcap_a;
  cap_rf_pkg::cap_meta_u            rcap_b;
  logic                             rvk_hit_a;
  logic                             rvk_hit_b;

  function automatic cap_rf_pkg::cap_meta_u clear_valid(input cap_rf_pkg::cap_meta_u cap);
    cap_rf_pkg::cap_meta_u res;
    res              = cap;
    res.fields.valid = 1'b0;
    return res;
  endfunction

  // one-hot strobes per register, enables folded in
  always_comb begin
    for (int i = 1; i < cap_rf_pkg::NumRegs; i++) begin
      we_dec[i]   = we_i      && (waddr_i     == cap_rf_pkg::AddrWidth'(i));
      trsv_dec[i] = trsv_en_i && (trsv_addr_i == cap_rf_pkg::AddrWidth'(i));
      trvk_dec[i] = trvk_en_i && (trvk_addr_i == cap_rf_pkg::AddrWidth'(i));
    end
  end

  for (genvar i = 1; i < cap_rf_pkg::NumRegs; i++) begin : g_regs
    logic trvk_clr;

    assign trvk_clr = trvk_dec[i] & trvk_clrtag_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_data_q[i] <= cap_rf_pkg::ZeroWord;
      end else if (we_dec[i]) begin
        rf_data_q[i] <= wdata_i;
      end
    end

    // a clearing revocation also strips the tag of a write landing this cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_cap_q[i] <= cap_rf_pkg::NullCap;
      end else if (trvk_clr && we_dec[i]) begin
        rf_cap_q[i] <= clear_valid(wcap_i);
      end else if (trvk_clr) begin
        rf_cap_q[i] <= clear_valid(rf_cap_q[i]);
      end else if (we_dec[i]) begin
        rf_cap_q[i] <= wcap_i;
      end
    end

    // reservation beats revocation
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rdy_q[i] <= 1'b1;
      end else if (trsv_dec[i]) begin
        rdy_q[i] <= 1'b0;
      end else if (trvk_dec[i]) begin
        rdy_q[i] <= 1'b1;
      end
    end

    assign rf_data[i]     = rf_data_q[i];
    assign rf_cap[i]      = rf_cap_q[i];
    assign cap_valid_o[i] = rf_cap_q[i].fields.valid;
  end

  // register 0
  assign rf_data[0]     = cap_rf_pkg::ZeroWord;
  assign rf_cap[0]      = cap_rf_pkg::NullCap;
  assign cap_valid_o[0] = 1'b0;

  assign rdata_a_o  = rf_data[raddr_a_i];
  assign rdata_b_o  = rf_data[raddr_b_i];
  assign rdbk_par_o = rf_data[rdbk_addr_i][cap_rf_pkg::DataWidth-1:cap_rf_pkg::WordWidth];

  assign rdy_vec_o = {rdy_q, 1'b1};

  // in-flight revocation shown on the read side already
  assign reg_rdy_o = rdy_vec_o | {trvk_dec, 1'b0};

  assign rcap_a    = rf_cap[raddr_a_i];
  assign rcap_b    = rf_cap[raddr_b_i];
  assign rvk_hit_a = trvk_en_i & trvk_clrtag_i & (trvk_addr_i == raddr_a_i);
  assign rvk_hit_b = trvk_en_i & trvk_clrtag_i & (trvk_addr_i == raddr_b_i);
  assign rcap_a_o  = rvk_hit_a ? clear_valid(rcap_a) : rcap_a;
  assign rcap_b_o  = rvk_hit_b ? clear_valid(rcap_b) : rcap_b;

endmodule

//--- hdl/revoke_ctrl.sv
/*
 * revocation controller: bitmap of revoked regions and the strobes
 * that reserve and release capability load destinations
 */
`timescale 1ns/1ps

module revoke_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // capability load tracking
  input  logic                                ld_issue_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]    ld_rd_i,
  input  logic                                ld_wb_i,
  // register file write port, observed
  input  logic                                we_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]    waddr_i,
  input  cap_rf_pkg::cap_meta_u               wcap_i,
  // bitmap programming
  input  logic                                rvk_we_i,
  input  logic [cap_rf_pkg::RvkIdxWidth-1:0]  rvk_idx_i,
  input  logic                                rvk_bit_i,
  // strobes to the register file
  output logic                                trsv_en_o,
  output logic [cap_rf_pkg::AddrWidth-1:0]    trsv_addr_o,
  output logic                                trvk_en_o,
  output logic [cap_rf_pkg::AddrWidth-1:0]    trvk_addr_o,
  output logic                                trvk_clrtag_o
);

  logic [2**cap_rf_pkg::RvkIdxWidth-1:0] bitmap_q;
  logic [cap_rf_pkg::RvkIdxWidth-1:0]    lkup_idx;
  logic                                  lkup_bit;
  logic                                  wb_hit;

  logic                                  trvk_en_q;
  logic                                  trvk_clrtag_q;
  logic [cap_rf_pkg::AddrWidth-1:0]      trvk_addr_q;

  // reservation goes straight through, r0 never waits
  assign trsv_en_o   = ld_issue_i & (ld_rd_i != '0);
  assign trsv_addr_o = ld_rd_i;

  // capability writeback, index taken from the low base bits
  assign wb_hit   = we_i & ld_wb_i & (waddr_i != '0);
  assign lkup_idx = wcap_i.fields.base[cap_rf_pkg::RvkIdxWidth-1:0];
  assign lkup_bit = bitmap_q[lkup_idx];

  // new bitmap value only visible to lookups after the edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bitmap_q <= '0;
    end else if (rvk_we_i) begin
      bitmap_q[rvk_idx_i] <= rvk_bit_i;
    end
  end

  // one revoke per writeback, issued the following cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trvk_en_q     <= 1'b0;
      trvk_clrtag_q <= 1'b0;
    end else begin
      trvk_en_q     <= wb_hit;
      trvk_clrtag_q <= wb_hit & lkup_bit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_hit) begin
      trvk_addr_q <= waddr_i;
    end
  end

  assign trvk_en_o     = trvk_en_q;
  assign trvk_addr_o   = trvk_addr_q;
  assign trvk_clrtag_o = trvk_clrtag_q;

endmodule

//--- hdl/rf_fault_monitor.sv
/*
 * register file fault monitor: write parity, parity and tag readback,
 * shadow ready vector and revoked tag checks, merged into a sticky alert
 */
`timescale 1ns/1ps

module rf_fault_monitor (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              we_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]  waddr_i,
  input  logic [cap_rf_pkg::DataWidth-1:0]  wdata_i,
  input  cap_rf_pkg::cap_meta_u             wcap_i,
  input  logic                              trsv_en_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]  trsv_addr_i,
  input  logic                              trvk_en_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]  trvk_addr_i,
  input  logic                              trvk_clrtag_i,
  input  logic [cap_rf_pkg::NumRegs-1:0]    rdy_vec_i,
  input  logic [cap_rf_pkg::NumRegs-1:0]    cap_valid_i,
  input  logic [cap_rf_pkg::ParWidth-1:0]   rdbk_par_i,
  output logic [cap_rf_pkg::AddrWidth-1:0]  rdbk_addr_o,
  output logic                              alert_o
);

  // registered write request
  logic                              we_q;
  logic [cap_rf_pkg::AddrWidth-1:0]  waddr_q;
  logic [cap_rf_pkg::WordWidth-1:0]  wdata_q;
  logic [cap_rf_pkg::ParWidth-1:0]   wpar_q;
  logic                              wvalid_q;

  // registered strobes
  logic                              trsv_en_q;
  logic [cap_rf_pkg::AddrWidth-1:0]  trsv_addr_q;
  logic                              trvk_en_q;
  logic                              trvk_clrtag_q;
  logic [cap_rf_pkg::AddrWidth-1:0]  trvk_addr_q;

  logic [cap_rf_pkg::NumRegs-1:0]    rdy_vec_q;
  logic [cap_rf_pkg::NumRegs-1:1]    shdw_rdy_q;
  logic                              rvk_same;
  logic                              par_err;
  logic                              rdbk_err;
  logic                              shdw_err;
  logic                              rvk_err;
  logic                              alert_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q          <= 1'b0;
      trsv_en_q     <= 1'b0;
      trvk_en_q     <= 1'b0;
      trvk_clrtag_q <= 1'b0;
      rdy_vec_q     <= '1;
    end else begin
      we_q          <= we_i;
      trsv_en_q     <= trsv_en_i;
      trvk_en_q     <= trvk_en_i;
      trvk_clrtag_q <= trvk_clrtag_i;
      rdy_vec_q     <= rdy_vec_i;
    end
  end

  always_ff @(posedge clk_i) begin
    waddr_q     <= waddr_i;
    wdata_q     <= wdata_i[cap_rf_pkg::WordWidth-1:0];
    wpar_q      <= wdata_i[cap_rf_pkg::DataWidth-1:cap_rf_pkg::WordWidth];
    wvalid_q    <= wcap_i.fields.valid;
    trsv_addr_q <= trsv_addr_i;
    trvk_addr_q <= trvk_addr_i;
  end

  // shadow ready vector, one cycle behind the real one
  for (genvar i = 1; i < cap_rf_pkg::NumRegs; i++) begin : g_shdw
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        shdw_rdy_q[i] <= 1'b1;
      end else if (trsv_en_q && (trsv_addr_q == cap_rf_pkg::AddrWidth'(i))) begin
        shdw_rdy_q[i] <= 1'b0;
      end else if (trvk_en_q && (trvk_addr_q == cap_rf_pkg::AddrWidth'(i))) begin
        shdw_rdy_q[i] <= 1'b1;
      end
    end
  end

  assign rdbk_addr_o = waddr_q;
  assign rvk_same    = trvk_en_q & trvk_clrtag_q & (trvk_addr_q == waddr_q);

  assign par_err  = we_q & (wpar_q != cap_rf_pkg::rf_par7(wdata_q));
  // stored parity and tag of the last write must match what was sent
  assign rdbk_err = we_q & (waddr_q != '0) &
                    ((rdbk_par_i != wpar_q) |
                     (cap_valid_i[waddr_q] != (wvalid_q & ~rvk_same)));
  assign shdw_err = ({shdw_rdy_q, 1'b1} != rdy_vec_q);
  assign rvk_err  = trvk_en_q & trvk_clrtag_q & cap_valid_i[trvk_addr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else if (par_err || rdbk_err || shdw_err || rvk_err) begin
      alert_q <= 1'b1;
    end
  end

  assign alert_o = alert_q;

endmodule

//--- hdl/cap_rf_top.sv
/*
 * capability register file top: register file, revocation
 * controller and fault monitor
 */
`timescale 1ns/1ps

module cap_rf_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [cap_rf_pkg::AddrWidth-1:0]    raddr_a_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]    raddr_b_i,
  input  logic                                we_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]    waddr_i,
  input  logic [cap_rf_pkg::DataWidth-1:0]    wdata_i,
  input  cap_rf_pkg::cap_meta_u               wcap_i,
  input  logic                                ld_issue_i,
  input  logic [cap_rf_pkg::AddrWidth-1:0]    ld_rd_i,
  input  logic                                ld_wb_i,
  input  logic                                rvk_we_i,
  input  logic [cap_rf_pkg::RvkIdxWidth-1:0]  rvk_idx_i,
  input  logic                                rvk_bit_i,
  output logic [cap_rf_pkg::DataWidth-1:0]    rdata_a_o,
  output logic [cap_rf_pkg::DataWidth-1:0]    rdata_b_o,
  output cap_rf_pkg::cap_meta_u               rcap_a_o,
  output cap_rf_pkg::cap_meta_u               rcap_b_o,
  output logic [cap_rf_pkg::NumRegs-1:0]      reg_rdy_o,
  output logic                                alert_o
);

  logic                              trsv_en;
  logic [cap_rf_pkg::AddrWidth-1:0]  trsv_addr;
  logic                              trvk_en;
  logic [cap_rf_pkg::AddrWidth-1:0]  trvk_addr;
  logic                              trvk_clrtag;
  logic [cap_rf_pkg::NumRegs-1:0]    rdy_vec;
  logic [cap_rf_pkg::NumRegs-1:0]    cap_valid;
  logic [cap_rf_pkg::AddrWidth-1:0]  rdbk_addr;
  logic [cap_rf_pkg::ParWidth-1:0]   rdbk_par;

  cap_regfile u_regfile (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .raddr_a_i     (raddr_a_i),
    .raddr_b_i     (raddr_b_i),
    .rdata_a_o     (rdata_a_o),
    .rdata_b_o     (rdata_b_o),
    .rcap_a_o      (rcap_a_o),
    .rcap_b_o      (rcap_b_o),
    .rdbk_addr_i   (rdbk_addr),
    .rdbk_par_o    (rdbk_par),
    .we_i          (we_i),
    .waddr_i       (waddr_i),
    .wdata_i       (wdata_i),
    .wcap_i        (wcap_i),
    .trsv_en_i     (trsv_en),
    .trsv_addr_i   (trsv_addr),
    .trvk_en_i     (trvk_en),
    .trvk_addr_i   (trvk_addr),
    .trvk_clrtag_i (trvk_clrtag),
    .rdy_vec_o     (rdy_vec),
    .cap_valid_o   (cap_valid),
    .reg_rdy_o     (reg_rdy_o)
  );

  revoke_ctrl u_revoke (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ld_issue_i    (ld_issue_i),
    .ld_rd_i       (ld_rd_i),
    .ld_wb_i       (ld_wb_i),
    .we_i          (we_i),
    .waddr_i       (waddr_i),
    .wcap_i        (wcap_i),
    .rvk_we_i      (rvk_we_i),
    .rvk_idx_i     (rvk_idx_i),
    .rvk_bit_i     (rvk_bit_i),
    .trsv_en_o     (trsv_en),
    .trsv_addr_o   (trsv_addr),
    .trvk_en_o     (trvk_en),
    .trvk_addr_o   (trvk_addr),
    .trvk_clrtag_o (trvk_clrtag)
  );

  rf_fault_monitor u_monitor (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .we_i          (we_i),
    .waddr_i       (waddr_i),
    .wdata_i       (wdata_i),
    .wcap_i        (wcap_i),
    .trsv_en_i     (trsv_en),
    .trsv_addr_i   (trsv_addr),
    .trvk_en_i     (trvk_en),
    .trvk_addr_i   (trvk_addr),
    .trvk_clrtag_i (trvk_clrtag),
    .rdy_vec_i     (rdy_vec),
    .cap_valid_i   (cap_valid),
    .rdbk_par_i    (rdbk_par),
    .rdbk_addr_o   (rdbk_addr),
    .alert_o       (alert_o)
  );

endmodule

//--- tb/cap_rf_props.sv
/*
 * concurrent assertions on the capability register file, bound into cap_regfile
 */
`timescale 1ns/1ps

module cap_rf_props (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic [cap_rf_pkg::AddrWidth-1:0]    raddr_a_i,
  input logic [cap_rf_pkg::AddrWidth-1:0]    raddr_b_i,
  input logic [cap_rf_pkg::DataWidth-1:0]    rdata_a_i,
  input logic [cap_rf_pkg::DataWidth-1:0]    rdata_b_i,
  input logic [cap_rf_pkg::CapWidth-1:0]     rcap_a_i,
  input logic [cap_rf_pkg::CapWidth-1:0]     rcap_b_i,
  input logic                                trsv_en_i,
  input logic [cap_rf_pkg::AddrWidth-1:0]    trsv_addr_i,
  input logic                                trvk_en_i,
  input logic [cap_rf_pkg::AddrWidth-1:0]    trvk_addr_i,
  input logic                                trvk_clrtag_i,
  input logic [cap_rf_pkg::NumRegs-1:0]      rdy_vec_i,
  input logic [cap_rf_pkg::NumRegs-1:0]      cap_valid_i,
  input logic [cap_rf_pkg::NumRegs-1:0]      reg_rdy_i
);

  int fail_cnt = 0;

  // r0 reads zero data, parity of zero, null metadata
  r0_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (raddr_a_i != '0 || (rdata_a_i == '0 && rcap_a_i == '0)) &&
    (raddr_b_i != '0 || (rdata_b_i == '0 && rcap_b_i == '0)))
    else begin
      $error("register 0 read returned nonzero data or metadata");
      fail_cnt++;
    end

  rsv_clears_rdy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (trsv_en_i && trsv_addr_i != '0) |=> !rdy_vec_i[$past(trsv_addr_i)])
    else begin
      $error("reservation did not clear the ready bit");
      fail_cnt++;
    end

  rvk_clears_tag: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (trvk_en_i && trvk_clrtag_i) |=> !cap_valid_i[$past(trvk_addr_i)])
    else begin
      $error("revoked capability still has its valid tag");
      fail_cnt++;
    end

  rdy_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (reg_rdy_i == '1))
    else begin
      $error("ready vector not all ones after reset");
      fail_cnt++;
    end

endmodule

bind cap_regfile cap_rf_props u_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .raddr_a_i     (raddr_a_i),
  .raddr_b_i     (raddr_b_i),
  .rdata_a_i     (rdata_a_o),
  .rdata_b_i     (rdata_b_o),
  .rcap_a_i      (rcap_a_o),
  .rcap_b_i      (rcap_b_o),
  .trsv_en_i     (trsv_en_i),
  .trsv_addr_i   (trsv_addr_i),
  .trvk_en_i     (trvk_en_i),
  .trvk_addr_i   (trvk_addr_i),
  .trvk_clrtag_i (trvk_clrtag_i),
  .rdy_vec_i     (rdy_vec_o),
  .cap_valid_i   (cap_valid_o),
  .reg_rdy_i     (reg_rdy_o)
);

//--- tb/cap_rf_tb.sv
/*
 * capability register file testbench, table driven against a
 * reference model of registers, ready bits, tags and revocation bitmap
 */
`timescale 1ns/1ps

module cap_rf_tb;

  localparam int ClkPeriod   = 4;
  localparam int ResetCycles = 16;
  localparam int NumRows     = 20;
  localparam int WatchdogNs  = ClkPeriod * NumRows * 4 + ClkPeriod * ResetCycles;

  // row kinds
  localparam int KRead    = 0;
  localparam int KWrite   = 1;
  localparam int KCapLoad = 2;
  localparam int KCapPair = 3;
  localparam int KBitmap  = 4;
  localparam int KBadPar  = 5;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic [4:0]            raddr_a;
  logic [4:0]            raddr_b;
  logic                  we;
  logic [4:0]            waddr;
  logic [38:0]           wdata;
  cap_rf_pkg::cap_meta_u wcap;
  logic                  ld_issue;
  logic [4:0]            ld_rd;
  logic                  ld_wb;
  logic                  rvk_we;
  logic [5:0]            rvk_idx;
  logic                  rvk_bit;
  logic [38:0]           rdata_a;
  logic [38:0]           rdata_b;
  cap_rf_pkg::cap_meta_u rcap_a;
  cap_rf_pkg::cap_meta_u rcap_b;
  logic [31:0]           reg_rdy;
  logic                  alert;

  // stimulus table
  int                    row_kind [NumRows];
  logic [4:0]            row_addr [NumRows];
  logic [31:0]           row_data [NumRows];
  cap_rf_pkg::cap_meta_u row_cap  [NumRows];
  logic                  row_bit  [NumRows];
  int                    n_rows = 0;

  // reference model
  logic [38:0]           exp_data [32];
  cap_rf_pkg::cap_meta_u exp_cap  [32];
  logic [31:0]           exp_rdy;
  logic [63:0]           exp_bitmap;
  logic                  exp_alert;

  int checks = 0;
  int errors = 0;
  int row_errs = 0;
  int prop_fails = 0;

  cap_rf_top u_cap_rf_top (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .raddr_a_i  (raddr_a),
    .raddr_b_i  (raddr_b),
    .we_i       (we),
    .waddr_i    (waddr),
    .wdata_i    (wdata),
    .wcap_i     (wcap),
    .ld_issue_i (ld_issue),
    .ld_rd_i    (ld_rd),
    .ld_wb_i    (ld_wb),
    .rvk_we_i   (rvk_we),
    .rvk_idx_i  (rvk_idx),
    .rvk_bit_i  (rvk_bit),
    .rdata_a_o  (rdata_a),
    .rdata_b_o  (rdata_b),
    .rcap_a_o   (rcap_a),
    .rcap_b_o   (rcap_b),
    .reg_rdy_o  (reg_rdy),
    .alert_o    (alert)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // parity bit k folds data bits k, k+7, k+14 ...
  function automatic logic [6:0] fold_parity(input logic [31:0] d);
    logic [6:0] p;
    p = '0;
    for (int k = 0; k < 7; k++) begin
      for (int j = k; j < 32; j += 7) begin
        p[k] ^= d[j];
      end
    end
    return p;
  endfunction

  function automatic logic [38:0] good_word(input logic [31:0] d);
    return {fold_parity(d), d};
  endfunction

  function automatic cap_rf_pkg::cap_meta_u rand_cap(input logic [8:0] base);
    cap_rf_pkg::cap_meta_u c;
    c.raw          = 38'({$urandom(), $urandom()});
    c.fields.valid = 1'b1;
    c.fields.base  = base;
    return c;
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      KRead:    return "read";
      KWrite:   return "write";
      KCapLoad: return "cap load";
      KCapPair: return "cap load pair";
      KBitmap:  return "bitmap set";
      default:  return "bad parity write";
    endcase
  endfunction

  task automatic add_row(input int kind, input logic [4:0] addr, input logic [31:0] data,
                         input cap_rf_pkg::cap_meta_u cap, input logic bit_val);
    row_kind[n_rows] = kind;
    row_addr[n_rows] = addr;
    row_data[n_rows] = data;
    row_cap[n_rows]  = cap;
    row_bit[n_rows]  = bit_val;
    n_rows++;
  endtask

  // read rows take port b address from data, bitmap rows take the index from it
  task automatic build_table();
    add_row(KRead,    5'd0,  32'd0,     rand_cap(9'h000), 1'b0);
    add_row(KRead,    5'd5,  32'd17,    rand_cap(9'h000), 1'b0);
    add_row(KRead,    5'd31, 32'd30,    rand_cap(9'h000), 1'b0);
    add_row(KWrite,   5'd1,  $urandom(), rand_cap(9'(($urandom()))), 1'b0);
    add_row(KWrite,   5'd2,  $urandom(), rand_cap(9'(($urandom()))), 1'b0);
    add_row(KWrite,   5'd31, $urandom(), rand_cap(9'(($urandom()))), 1'b0);
    add_row(KWrite,   5'd0,  $urandom(), rand_cap(9'(($urandom()))), 1'b0);
    add_row(KRead,    5'd1,  32'd2,     rand_cap(9'h000), 1'b0);
    add_row(KRead,    5'd0,  32'd31,    rand_cap(9'h000), 1'b0);
    add_row(KCapLoad, 5'd3,  $urandom(), rand_cap(9'h00a), 1'b0);
    add_row(KBitmap,  5'd0,  32'd12,    rand_cap(9'h000), 1'b1);
    // only the low six base bits index the bitmap
    add_row(KCapLoad, 5'd4,  $urandom(), rand_cap(9'h10c), 1'b0);
    add_row(KRead,    5'd4,  32'd3,     rand_cap(9'h000), 1'b0);
    add_row(KBitmap,  5'd0,  32'd20,    rand_cap(9'h000), 1'b1);
    add_row(KCapPair, 5'd6,  $urandom(), rand_cap(9'h014), 1'b0);
    add_row(KCapPair, 5'd8,  $urandom(), rand_cap(9'h013), 1'b0);
    add_row(KWrite,   5'd10, $urandom(), rand_cap(9'(($urandom()))), 1'b0);
    add_row(KRead,    5'd10, 32'd6,     rand_cap(9'h000), 1'b0);
    add_row(KBadPar,  5'd11, $urandom(), rand_cap(9'(($urandom()))), 1'b0);
    add_row(KRead,    5'd11, 32'd0,     rand_cap(9'h000), 1'b0);
  endtask

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      row_errs++;
    end
  endtask

  task automatic check_outputs();
    check_value("rdata_a", rdata_a, exp_data[raddr_a]);
    check_value("rdata_b", rdata_b, exp_data[raddr_b]);
    check_value("rcap_a", rcap_a.raw, exp_cap[raddr_a].raw);
    check_value("rcap_b", rcap_b.raw, exp_cap[raddr_b].raw);
    check_value("reg_rdy", reg_rdy, exp_rdy);
    check_value("alert", alert, exp_alert);
  endtask

  task automatic model_write(input logic [4:0] addr, input logic [38:0] word,
                             input cap_rf_pkg::cap_meta_u cap);
    if (addr != '0) begin
      exp_data[addr] = word;
      exp_cap[addr]  = cap;
    end
  endtask

  task automatic model_reserve(input logic [4:0] addr);
    if (addr != '0) exp_rdy[addr] = 1'b0;
  endtask

  task automatic model_revoke(input logic [4:0] addr, input logic hit);
    if (addr != '0) begin
      exp_rdy[addr] = 1'b1;
      if (hit) exp_cap[addr].fields.valid = 1'b0;
    end
  endtask

  task automatic drive_write(input logic [4:0] addr, input logic [38:0] word,
                             input cap_rf_pkg::cap_meta_u cap, input logic wb);
    we    <= 1'b1;
    waddr <= addr;
    wdata <= word;
    wcap  <= cap;
    ld_wb <= wb;
  endtask

  task automatic do_read(input logic [4:0] addr_a, input logic [4:0] addr_b);
    @(posedge clk_i);
    raddr_a <= addr_a;
    raddr_b <= addr_b;
    @(negedge clk_i);
    check_outputs();
  endtask

  task automatic do_write(input logic [4:0] addr, input logic [38:0] word,
                          input cap_rf_pkg::cap_meta_u cap);
    @(posedge clk_i);
    drive_write(addr, word, cap, 1'b0);
    raddr_a <= addr;
    raddr_b <= addr;
    @(posedge clk_i);
    we <= 1'b0;
    model_write(addr, word, cap);
    @(negedge clk_i);
    check_outputs();
  endtask

  task automatic do_bitmap(input logic [5:0] idx, input logic bit_val);
    @(posedge clk_i);
    rvk_we  <= 1'b1;
    rvk_idx <= idx;
    rvk_bit <= bit_val;
    @(posedge clk_i);
    rvk_we <= 1'b0;
    exp_bitmap[idx] = bit_val;
    @(negedge clk_i);
    check_outputs();
  endtask

  // issue, writeback, then the revoke cycle with bypass, then stored state
  task automatic do_capload(input logic [4:0] rd, input logic [31:0] d,
                            input cap_rf_pkg::cap_meta_u cap);
    logic hit;
    hit = exp_bitmap[cap.fields.base[5:0]];
    @(posedge clk_i);
    ld_issue <= 1'b1;
    ld_rd    <= rd;
    raddr_a  <= rd;
    raddr_b  <= rd;
    @(posedge clk_i);
    ld_issue <= 1'b0;
    drive_write(rd, good_word(d), cap, 1'b1);
    model_reserve(rd);
    @(negedge clk_i);
    check_outputs();
    @(posedge clk_i);
    we    <= 1'b0;
    ld_wb <= 1'b0;
    model_write(rd, good_word(d), cap);
    model_revoke(rd, hit);
    @(negedge clk_i);
    check_outputs();
    @(negedge clk_i);
    check_outputs();
  endtask

  // two loads, writebacks on back-to-back cycles to rd and rd + 1
  task automatic do_cappair(input logic [4:0] rd, input logic [31:0] d,
                            input cap_rf_pkg::cap_meta_u cap);
    logic [4:0]            rd2;
    cap_rf_pkg::cap_meta_u cap2;
    logic                  hit1;
    logic                  hit2;
    rd2              = rd + 5'd1;
    cap2             = cap;
    cap2.fields.base = cap.fields.base + 9'd1;
    hit1             = exp_bitmap[cap.fields.base[5:0]];
    hit2             = exp_bitmap[cap2.fields.base[5:0]];
    @(posedge clk_i);
    ld_issue <= 1'b1;
    ld_rd    <= rd;
    raddr_a  <= rd;
    raddr_b  <= rd2;
    @(posedge clk_i);
    ld_rd <= rd2;
    model_reserve(rd);
    @(negedge clk_i);
    check_outputs();
    @(posedge clk_i);
    ld_issue <= 1'b0;
    drive_write(rd, good_word(d), cap, 1'b1);
    model_reserve(rd2);
    @(negedge clk_i);
    check_outputs();
    @(posedge clk_i);
    drive_write(rd2, good_word(~d), cap2, 1'b1);
    model_write(rd, good_word(d), cap);
    model_revoke(rd, hit1);
    @(negedge clk_i);
    check_outputs();
    @(posedge clk_i);
    we    <= 1'b0;
    ld_wb <= 1'b0;
    model_write(rd2, good_word(~d), cap2);
    model_revoke(rd2, hit2);
    @(negedge clk_i);
    check_outputs();
    @(negedge clk_i);
    check_outputs();
  endtask

  task automatic do_badpar(input logic [4:0] addr, input logic [31:0] d,
                           input cap_rf_pkg::cap_meta_u cap);
    logic [38:0] word;
    word = {fold_parity(d) ^ 7'h01, d};
    do_write(addr, word, cap);
    // alert registers one cycle after the write, sticky until reset
    exp_alert = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      check_outputs();
    end
  endtask

  initial begin
    void'($urandom(71));
    rst_ni   = 1'b0;
    raddr_a  = '0;
    raddr_b  = '0;
    we       = 1'b0;
    waddr    = '0;
    wdata    = '0;
    wcap     = '0;
    ld_issue = 1'b0;
    ld_rd    = '0;
    ld_wb    = 1'b0;
    rvk_we   = 1'b0;
    rvk_idx  = '0;
    rvk_bit  = 1'b0;
    for (int r = 0; r < 32; r++) begin
      exp_data[r] = good_word(32'd0);
      exp_cap[r]  = '0;
    end
    exp_rdy    = '1;
    exp_bitmap = '0;
    exp_alert  = 1'b0;
    build_table();
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < NumRows; i++) begin
      row_errs = 0;
      case (row_kind[i])
        KRead:    do_read(row_addr[i], row_data[i][4:0]);
        KWrite:   do_write(row_addr[i], good_word(row_data[i]), row_cap[i]);
        KCapLoad: do_capload(row_addr[i], row_data[i], row_cap[i]);
        KCapPair: do_cappair(row_addr[i], row_data[i], row_cap[i]);
        KBitmap:  do_bitmap(row_data[i][5:0], row_bit[i]);
        default:  do_badpar(row_addr[i], row_data[i], row_cap[i]);
      endcase
      if (row_errs == 0) begin
        $display("row %0d %s r%0d: pass", i, kind_name(row_kind[i]), row_addr[i]);
      end else begin
        $display("row %0d %s r%0d: %0d mismatches", i, kind_name(row_kind[i]), row_addr[i],
                 row_errs);
      end
    end
    prop_fails = u_cap_rf_top.u_regfile.u_props.fail_cnt;
    $display("rows %0d, checks %0d, mismatches %0d, assertion failures %0d",
             NumRows, checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("watchdog expired after %0d ns before all rows finished", WatchdogNs);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- cap_rf.f
hdl/cap_rf_pkg.sv
hdl/cap_regfile.sv
hdl/revoke_ctrl.sv
hdl/rf_fault_monitor.sv
hdl/cap_rf_top.sv
tb/cap_rf_props.sv
tb/cap_rf_tb.sv
